//--- src/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int unsigned xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  localparam word_t reset_vector = 32'h8000_0000;

  typedef enum logic [6:0] {
    OPC_OP     = 7'b011_0011,
    OPC_OP_IMM = 7'b001_0011,
    OPC_LOAD   = 7'b000_0011,
    OPC_STORE  = 7'b010_0011,
    OPC_BRANCH = 7'b110_0011,
    OPC_JAL    = 7'b110_1111,
    OPC_JALR   = 7'b110_0111,
    OPC_LUI    = 7'b011_0111,
    OPC_AUIPC  = 7'b001_0111,
    OPC_SYSTEM = 7'b111_0011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_ALU, WB_LOAD, WB_PC_PLUS4, WB_IMM
  } wb_sel_e;

  // the six instruction formats, msb first
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    opcode_e    opcode;
  } inst_r_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    opcode_e     opcode;
  } inst_i_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_e    opcode;
  } inst_s_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } inst_b_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_addr_t   rd;
    opcode_e     opcode;
  } inst_u_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_addr_t  rd;
    opcode_e    opcode;
  } inst_j_t;

  typedef union packed {
    inst_r_t r;
    inst_i_t i;
    inst_s_t s;
    inst_b_t b;
    inst_u_t u;
    inst_j_t j;
  } inst_u;

  typedef struct packed {
    alu_op_e alu_op;
    logic    a_is_pc;   // operand a is pc, else rs1
    logic    b_is_imm;  // operand b is imm, else rs2
    wb_sel_e wb_sel;
    logic    reg_we;
    logic    mem_re;
    logic    mem_we;
    logic    is_branch;
    logic    is_jump;   // jal or jalr
    logic    is_jalr;
  } ctrl_t;

  typedef struct packed {
    word_t      addr;
    word_t      wdata;
    logic [3:0] wmask;  // one bit per byte lane
    logic       we;
    logic       re;
  } dmem_req_t;

endpackage

`default_nettype wire

//--- src/rv_control.sv
`default_nettype none

module rv_control (
  input  rv_pkg::inst_u inst,
  input  logic          run,
  output rv_pkg::ctrl_t ctrl,
  output logic          halt
);
  import rv_pkg::*;

  // funct3 to alu op, sub only exists for register ops
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt,
                                      input logic is_reg);
    case (f3)
      3'b000:  return (alt && is_reg) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  logic alt;

  assign alt = inst.r.funct7[5];

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = ALU_ADD;
    ctrl.wb_sel = WB_ALU;
    halt        = 1'b0;
    case (inst.r.opcode)
      OPC_OP: begin
        ctrl.alu_op = alu_sel(inst.r.funct3, alt, 1'b1);
        ctrl.reg_we = 1'b1;
      end
      OPC_OP_IMM: begin
        ctrl.alu_op   = alu_sel(inst.r.funct3, alt, 1'b0);
        ctrl.b_is_imm = 1'b1;
        ctrl.reg_we   = 1'b1;
      end
      OPC_LOAD: begin
        ctrl.b_is_imm = 1'b1;  // address = rs1 + imm
        ctrl.wb_sel   = WB_LOAD;
        ctrl.reg_we   = 1'b1;
        ctrl.mem_re   = 1'b1;
      end
      OPC_STORE: begin
        ctrl.b_is_imm = 1'b1;
        ctrl.mem_we   = 1'b1;
      end
      OPC_BRANCH: ctrl.is_branch = 1'b1;  // compare rs1 with rs2
      OPC_JAL: begin
        ctrl.is_jump = 1'b1;
        ctrl.wb_sel  = WB_PC_PLUS4;
        ctrl.reg_we  = 1'b1;
      end
      OPC_JALR: begin
        ctrl.is_jump = 1'b1;
        ctrl.is_jalr = 1'b1;
        ctrl.wb_sel  = WB_PC_PLUS4;
        ctrl.reg_we  = 1'b1;
      end
      OPC_LUI: begin
        ctrl.wb_sel = WB_IMM;
        ctrl.reg_we = 1'b1;
      end
      OPC_AUIPC: begin
        ctrl.a_is_pc  = 1'b1;
        ctrl.b_is_imm = 1'b1;
        ctrl.reg_we   = 1'b1;
      end
      OPC_SYSTEM: halt = 1'b1;
      default: ;  // unknown opcode acts as a nop
    endcase
    // nothing leaves the core before the first fetch
    if (!run) begin
      ctrl.reg_we = 1'b0;
      ctrl.mem_re = 1'b0;
      ctrl.mem_we = 1'b0;
      halt        = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- src/rv_imm_gen.sv
`default_nettype none

module rv_imm_gen (
  input  rv_pkg::inst_u inst,
  output rv_pkg::word_t imm
);
  import rv_pkg::*;

  logic is_shift;

  // slli, srli, srai carry a shamt in the imm field
  assign is_shift = (inst.i.funct3 == 3'b001) || (inst.i.funct3 == 3'b101);

  always_comb begin
    case (inst.r.opcode)
      OPC_OP_IMM: begin
        if (is_shift) imm = {27'b0, inst.r.rs2};
        else imm = {{20{inst.i.imm[11]}}, inst.i.imm};
      end
      OPC_LOAD, OPC_JALR: imm = {{20{inst.i.imm[11]}}, inst.i.imm};
      OPC_STORE: imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
      OPC_BRANCH:
        imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11, inst.b.imm_10_5,
               inst.b.imm_4_1, 1'b0};
      OPC_LUI, OPC_AUIPC: imm = {inst.u.imm_31_12, 12'b0};
      OPC_JAL:
        imm = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12, inst.j.imm_11,
               inst.j.imm_10_1, 1'b0};
      default: imm = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/rv_regfile.sv
`default_nettype none

module rv_regfile (
  input  logic              clk,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  input  rv_pkg::reg_addr_t rd,
  input  logic              we,
  input  rv_pkg::word_t     wdata,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);
  import rv_pkg::*;

  word_t regs [1:31];  // x0 has no storage

  always_ff @(posedge clk) begin
    if (we && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- src/rv_alu.sv
`default_nettype none

module rv_alu (
  input  rv_pkg::ctrl_t ctrl,
  input  logic [2:0]    funct3,
  input  rv_pkg::word_t pc,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  input  rv_pkg::word_t imm,
  output rv_pkg::word_t result,
  output logic          take_branch
);
  import rv_pkg::*;

  word_t       op_a;
  word_t       op_b;
  logic [32:0] diff;  // extra bit is the borrow
  logic        eq;
  logic        lt;
  logic        ltu;

  assign op_a = ctrl.a_is_pc ? pc : rs1_data;
  assign op_b = ctrl.b_is_imm ? imm : rs2_data;

  // one subtractor for sub, slt, sltu and branches
  // for branches the operands are rs1 and rs2
  assign diff = {1'b0, op_a} - {1'b0, op_b};
  assign eq   = (diff[31:0] == '0);
  assign ltu  = diff[32];
  assign lt   = (op_a[31] != op_b[31]) ? op_a[31] : diff[31];  // signs differ, a negative wins

  always_comb begin
    case (ctrl.alu_op)
      ALU_SUB:  result = diff[31:0];
      ALU_XOR:  result = op_a ^ op_b;
      ALU_OR:   result = op_a | op_b;
      ALU_AND:  result = op_a & op_b;
      ALU_SLT:  result = {31'b0, lt};
      ALU_SLTU: result = {31'b0, ltu};
      ALU_SLL:  result = op_a << op_b[4:0];
      ALU_SRL:  result = op_a >> op_b[4:0];
      ALU_SRA:  result = $signed(op_a) >>> op_b[4:0];
      default:  result = op_a + op_b;  // add, also addresses and auipc
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  take_branch = eq;   // beq
      3'b001:  take_branch = !eq;  // bne
      3'b100:  take_branch = lt;
      3'b101:  take_branch = !lt;
      3'b110:  take_branch = ltu;
      3'b111:  take_branch = !ltu;
      default: take_branch = 1'b0;
    endcase
    if (!ctrl.is_branch) take_branch = 1'b0;
  end

endmodule

`default_nettype wire

//--- src/rv_fetch.sv
`default_nettype none

module rv_fetch (
  input  logic          clk,
  input  logic          arst_n,
  input  rv_pkg::ctrl_t ctrl,
  input  logic          halt,
  input  logic          take_branch,
  input  rv_pkg::word_t imm,
  input  rv_pkg::word_t rs1_data,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t pc_plus4,
  output logic          run
);
  import rv_pkg::*;

  word_t target;
  word_t pc_next;

  assign pc_plus4 = pc + 32'd4;

  // jalr clears bit 0 of the sum
  assign target  = ctrl.is_jalr ? ((rs1_data + imm) & ~32'd1) : (pc + imm);
  assign pc_next = (ctrl.is_jump || take_branch) ? target : pc_plus4;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc  <= reset_vector;
      run <= 1'b0;
    end else begin
      run <= 1'b1;  // first edge out of reset only arms the core
      if (run && !halt) begin
        pc <= pc_next;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/rv_lsu.sv
`default_nettype none

module rv_lsu (
  input  rv_pkg::ctrl_t     ctrl,
  input  logic [2:0]        funct3,
  input  rv_pkg::word_t     addr,
  input  rv_pkg::word_t     rs2_data,
  input  rv_pkg::word_t     dmem_rdata,
  output rv_pkg::dmem_req_t dmem_req,
  output rv_pkg::word_t     load_data
);
  import rv_pkg::*;

  logic [1:0] offset;
  logic [3:0] mask;
  word_t      lane;  // read word moved down to byte 0

  assign offset = addr[1:0];

  // size from funct3[1:0], misaligned accesses get no lanes
  always_comb begin
    case (funct3[1:0])
      2'b00:   mask = 4'b0001 << offset;
      2'b01:   mask = offset[0] ? 4'b0000 : (4'b0011 << offset);
      2'b10:   mask = (offset == 2'b00) ? 4'b1111 : 4'b0000;
      default: mask = 4'b0000;
    endcase
  end

  assign dmem_req.addr  = addr;
  assign dmem_req.wdata = rs2_data << {offset, 3'b000};
  assign dmem_req.wmask = ctrl.mem_we ? mask : 4'b0000;
  assign dmem_req.we    = ctrl.mem_we;
  assign dmem_req.re    = ctrl.mem_re;

  assign lane = dmem_rdata >> {offset, 3'b000};

  always_comb begin
    case (funct3)
      3'b000:  load_data = {{24{lane[7]}}, lane[7:0]};    // lb
      3'b001:  load_data = {{16{lane[15]}}, lane[15:0]};  // lh
      3'b010:  load_data = dmem_rdata;
      3'b100:  load_data = {24'b0, lane[7:0]};            // lbu
      3'b101:  load_data = {16'b0, lane[15:0]};           // lhu
      default: load_data = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/rv_core.sv
`default_nettype none

module rv_core (
  input  logic              clk,
  input  logic              arst_n,
  input  rv_pkg::word_t     imem_rdata,
  input  rv_pkg::word_t     dmem_rdata,
  output rv_pkg::word_t     imem_addr,
  output rv_pkg::dmem_req_t dmem_req,
  output logic              halt
);
  import rv_pkg::*;

  inst_u inst;
  ctrl_t ctrl;
  logic  run;
  logic  take_branch;
  word_t pc;
  word_t pc_plus4;
  word_t imm;
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_result;
  word_t load_data;
  word_t wb_data;

  assign inst      = imem_rdata;
  assign imem_addr = pc;

  // write-back source
  assign wb_data = (ctrl.wb_sel == WB_LOAD)     ? load_data :
                   (ctrl.wb_sel == WB_PC_PLUS4) ? pc_plus4 :
                   (ctrl.wb_sel == WB_IMM)      ? imm : alu_result;

  rv_control i_control (
    .inst (inst),
    .run  (run),
    .ctrl (ctrl),
    .halt (halt)
  );

  rv_imm_gen i_imm_gen (
    .inst (inst),
    .imm  (imm)
  );

  rv_regfile i_regfile (
    .clk      (clk),
    .rs1      (inst.r.rs1),
    .rs2      (inst.r.rs2),
    .rd       (inst.r.rd),
    .we       (ctrl.reg_we),
    .wdata    (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_alu i_alu (
    .ctrl        (ctrl),
    .funct3      (inst.r.funct3),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .imm         (imm),
    .result      (alu_result),
    .take_branch (take_branch)
  );

  rv_fetch i_fetch (
    .clk         (clk),
    .arst_n      (arst_n),
    .ctrl        (ctrl),
    .halt        (halt),
    .take_branch (take_branch),
    .imm         (imm),
    .rs1_data    (rs1_data),
    .pc          (pc),
    .pc_plus4    (pc_plus4),
    .run         (run)
  );

  rv_lsu i_lsu (
    .ctrl       (ctrl),
    .funct3     (inst.r.funct3),
    .addr       (alu_result),  // rs1 + imm for loads and stores
    .rs2_data   (rs2_data),
    .dmem_rdata (dmem_rdata),
    .dmem_req   (dmem_req),
    .load_data  (load_data)
  );

endmodule

`default_nettype wire

//--- tests/tb_rv_core.sv
`default_nettype none

module tb_rv_core;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_pkg::*;

  // word offsets inside the stimulus image
  localparam int unsigned data_base  = 'h008;
  localparam int unsigned prog_base  = 'h100;
  localparam int unsigned store_base = 'h200;

  logic      clk;
  logic      arst_n;
  word_t     imem_rdata;
  word_t     dmem_rdata;
  word_t     imem_addr;
  dmem_req_t dmem_req;
  logic      halt;

  word_t       stim [0:1023];
  word_t       imem [0:255];
  word_t       dmem [0:255];  // 0x1000 lands on word 0
  dmem_req_t   req_q;         // request as seen between edges
  int unsigned n_prog;
  int unsigned n_data;
  int unsigned n_stores;
  int unsigned limit_cycles;
  word_t       final_pc;

  rv_core i_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .imem_rdata (imem_rdata),
    .dmem_rdata (dmem_rdata),
    .imem_addr  (imem_addr),
    .dmem_req   (dmem_req),
    .halt       (halt)
  );

  always #10 clk = ~clk;

  function automatic int unsigned imem_index(input word_t a);
    word_t off;
    off = a - reset_vector;
    return int'(off[9:2]);
  endfunction

  function automatic dmem_req_t expected_store(input int unsigned k);
    dmem_req_t   r;
    int unsigned at;
    at      = store_base + 3 * k;
    r.addr  = stim[at];
    r.wdata = stim[at+1];
    r.wmask = stim[at+2][3:0];
    r.we    = 1'b1;
    r.re    = 1'b0;
    return r;
  endfunction

  assign imem_rdata = imem[imem_index(imem_addr)];
  assign dmem_rdata = dmem_req.re ? dmem[dmem_req.addr[9:2]] : '0;

  always @(negedge clk) req_q <= dmem_req;

  always @(posedge clk) begin
    if (req_q.we) begin
      for (int b = 0; b < 4; b++) begin
        if (req_q.wmask[b]) dmem[req_q.addr[9:2]][8*b +: 8] <= req_q.wdata[8*b +: 8];
      end
    end
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("** Error: %s expected %h, got %h", name, exp, act));
    end
  endtask

  task automatic check_mask(input string name, input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("** Error: %s expected %h, got %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_with_failure($sformatf("** Error: %s expected %h, got %h", name, exp, act));
    end
  endtask

  task automatic check_store(input dmem_req_t exp, input dmem_req_t act);
    check_word("dmem_req.addr", exp.addr, act.addr);
    check_word("dmem_req.wdata", exp.wdata, act.wdata);
    check_mask("dmem_req.wmask", exp.wmask, act.wmask);
    check_bit("dmem_req.re", exp.re, act.re);
  endtask

  // core must stay quiet until the run flag sets
  task automatic check_idle();
    check_word("imem_addr", reset_vector, imem_addr);
    check_bit("dmem_req.we", 1'b0, dmem_req.we);
    check_bit("dmem_req.re", 1'b0, dmem_req.re);
    check_bit("halt", 1'b0, halt);
  endtask

  initial begin
    int unsigned n_seen;
    dmem_req_t   exp;
    clk          = 1'b0;
    arst_n       = 1'b0;
    n_seen       = 0;
    limit_cycles = 0;
    $readmemh("tests/rv_core_stimulus.txt", stim);
    n_prog   = stim[0];
    n_data   = stim[1];
    n_stores = stim[2];
    final_pc = stim[3];
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
      dmem[i] = '0;
    end
    for (int i = 0; i < n_prog; i++) imem[i] = stim[prog_base+i];
    for (int i = 0; i < n_data; i++) dmem[i] = stim[data_base+i];
    limit_cycles = n_prog * 4 + 50;

    repeat (10) begin
      @(negedge clk);
      check_idle();
    end
    arst_n = 1'b1;
    check_idle();  // run flag only sets at the next edge

    while (!halt) begin
      @(negedge clk);
      if (!halt && dmem_req.we) begin
        if (n_seen >= n_stores) stop_with_failure("a store appeared beyond the expected list");
        exp = expected_store(n_seen);
        check_store(exp, dmem_req);
        n_seen++;
      end
    end

    check_word("imem_addr", final_pc, imem_addr);
    repeat (5) begin
      @(negedge clk);
      check_word("imem_addr", final_pc, imem_addr);
      check_bit("halt", 1'b1, halt);
      check_bit("dmem_req.we", 1'b0, dmem_req.we);
    end

    if (n_seen != n_stores) begin
      stop_with_failure($sformatf("saw %0d stores but the list holds %0d", n_seen, n_stores));
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

  // reset time plus program length budget
  initial begin
    wait (limit_cycles != 0);
    repeat (limit_cycles + 12) @(posedge clk);
    stop_with_failure("watchdog expired because halt never arrived");
  end

endmodule

`default_nettype wire

//--- tests/rv_core_stimulus.txt
// @000 header: program words, data words, store count, final pc
// @008 data words at 0x1000, @100 program at 0x80000000, @200 stores: addr wdata wmask
@000
0000005E 00000002 00000027 80000174
@008
80FF7F01 7FFF8001
@100
// setup: x1 = 0x1000, x2 = 0x1100, x3 = 100, x4 = -7
000010B7 10008113 06400193 FF900213
// add sub xor or and, each stored
004182B3 00512023 404182B3 00512223 0041C2B3 00512423 0041E2B3 00512623
0041F2B3 00512823
// slt sltu edge cases
003222B3 00512A23 003232B3 00512C23 0041B2B3 00512E23
// slli srli srai sll andi
00421293 02512023 00425293 02512223 40125293 02512423 003192B3 02512623
0F027293 02512823
// lb lb lb lbu lbu lh lh lhu lhu lw
00008283 02512A23 00208283 02512C23 00308283 02512E23 0030C283 04512023
0010C283 04512223 00409283 04512423 00609283 04512623 0040D283 04512823
0020D283 04512A23 0000A283 04512C23
// x6 = 0x12345678, sb at four offsets, sh at two
12345337 67830313 08610023 086100A3 08610123 086101A3 08611223 08611323
// branch taken skips poison, not taken stores a marker
00318463 0E412E23 00418463 08312823 00419463 0E412E23 00319463 08312A23
00324463 0E412E23 0041C463 08312C23 0041D463 0E412E23 00325463 08312E23
0041E463 0E412E23 00326463 0A312023 00327463 0E412E23 0041F463 0A312223
// jal, auipc, jalr, lui, then ecall
0080046F 0E412E23 0A812423 00000497 01148567 0E412E23 0E412E23 0A912623
0AA12823 ABCDE5B7 0AB12A23 00000073
@200
00001100 0000005D F  00001104 0000006B F  00001108 FFFFFF9D F  0000110C FFFFFFFD F
00001110 00000060 F  00001114 00000001 F  00001118 00000000 F  0000111C 00000001 F
00001120 FFFFFF90 F  00001124 0FFFFFFF F  00001128 FFFFFFFC F  0000112C 00000640 F
00001130 000000F0 F  00001134 00000001 F  00001138 FFFFFFFF F  0000113C FFFFFF80 F
00001140 00000080 F  00001144 0000007F F  00001148 FFFF8001 F  0000114C 00007FFF F
00001150 00008001 F  00001154 000080FF F  00001158 80FF7F01 F
00001180 12345678 1  00001181 34567800 2  00001182 56780000 4  00001183 78000000 8
00001184 12345678 3  00001186 56780000 C
00001190 00000064 F  00001194 00000064 F  00001198 00000064 F  0000119C 00000064 F
000011A0 00000064 F  000011A4 00000064 F
000011A8 8000014C F  000011AC 80000154 F  000011B0 8000015C F  000011B4 ABCDE000 F

//--- src.f
src/rv_pkg.sv
src/rv_control.sv
src/rv_imm_gen.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_fetch.sv
src/rv_lsu.sv
src/rv_core.sv
tests/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - src/rv_pkg.sv
  - src/rv_control.sv
  - src/rv_imm_gen.sv
  - src/rv_regfile.sv
  - src/rv_alu.sv
  - src/rv_fetch.sv
  - src/rv_lsu.sv
  - src/rv_core.sv
  - target: test
    files:
      - tests/tb_rv_core.sv
